// File: hw/rv_isa_pkg.sv
package rv_isa_pkg;

  typedef logic [31:0] word_t;     // data, instruction or address
  typedef logic [4:0]  reg_addr_t; // x0..x31
  typedef logic [6:0]  opcode_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [3:0]  alu_op_t;

  // alu operations
  localparam alu_op_t alu_add  = 4'd0;
  localparam alu_op_t alu_sub  = 4'd1;
  localparam alu_op_t alu_sll  = 4'd2;
  localparam alu_op_t alu_slt  = 4'd3;
  localparam alu_op_t alu_sltu = 4'd4;
  localparam alu_op_t alu_xor  = 4'd5;
  localparam alu_op_t alu_srl  = 4'd6;
  localparam alu_op_t alu_sra  = 4'd7;
  localparam alu_op_t alu_or   = 4'd8;
  localparam alu_op_t alu_and  = 4'd9;

  // major opcodes, rv32i base table
  localparam opcode_t op_reg_reg  = 7'b01_100_11;
  localparam opcode_t op_reg_imm  = 7'b00_100_11;
  localparam opcode_t op_lui      = 7'b01_101_11;
  localparam opcode_t op_auipc    = 7'b00_101_11;
  localparam opcode_t op_jal      = 7'b11_011_11;
  localparam opcode_t op_jalr     = 7'b11_001_11;
  localparam opcode_t op_branch   = 7'b11_000_11;
  localparam opcode_t op_misc_mem = 7'b00_011_11;
  localparam opcode_t op_system   = 7'b11_100_11;

  // funct7 field values
  localparam logic [6:0] funct7_base = 7'b000_0000;
  localparam logic [6:0] funct7_alt  = 7'b010_0000; // sub, sra, srai

endpackage

// File: hw/core_cfg_pkg.sv
package core_cfg_pkg;

  // sequencer states, two cycles per instruction
  typedef enum logic [1:0] {
    st_idle,
    st_fetch,
    st_exec,
    st_halt
  } core_state_t;

  typedef logic [31:0] count_t; // wraps silently

  // pc after reset
  localparam rv_isa_pkg::word_t reset_pc = 32'h0000_0000;

endpackage

// File: hw/insn_mem.sv
module insn_mem #(
  parameter int imem_words = 256,
  localparam int addr_w = $clog2(imem_words)
) (
  input  logic              clk,
  input  logic              load_we,
  input  logic [addr_w-1:0] load_addr,
  input  rv_isa_pkg::word_t load_data,
  input  logic              fetch,
  input  rv_isa_pkg::word_t pc,
  output rv_isa_pkg::word_t insn
);
  import rv_isa_pkg::*;

  word_t             mem [imem_words];
  logic [addr_w-1:0] word_idx;

  // byte address to word index wrapping at the memory depth
  assign word_idx = addr_w'((pc >> 2) % imem_words);

  always_ff @(posedge clk) begin
    if (load_we) begin
      mem[load_addr] <= load_data; // outside program load
    end
    if (fetch) begin
      insn <= mem[word_idx]; // held through exec
    end
  end

endmodule

// File: hw/reg_file.sv
module reg_file (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_isa_pkg::reg_addr_t rs1,
  input  rv_isa_pkg::reg_addr_t rs2,
  input  rv_isa_pkg::reg_addr_t rd,
  input  logic                  we,
  input  logic                  commit,
  input  rv_isa_pkg::word_t     wdata,
  output rv_isa_pkg::word_t     rs1_data,
  output rv_isa_pkg::word_t     rs2_data
);
  import rv_isa_pkg::*;

  word_t regs [32];

  // x0 stays zero, decode never raises we for rd == 0
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (commit && we) begin
      regs[rd] <= wdata;
    end
  end

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

endmodule

// File: hw/insn_decode.sv
module insn_decode (
  input  rv_isa_pkg::word_t     insn,
  output rv_isa_pkg::reg_addr_t rs1,
  output rv_isa_pkg::reg_addr_t rs2,
  output rv_isa_pkg::reg_addr_t rd,
  output rv_isa_pkg::word_t     imm,
  output rv_isa_pkg::alu_op_t   alu_op,
  output logic                  a_sel_pc,
  output logic                  a_zero,
  output logic                  b_imm,
  output logic                  link,
  output logic                  rd_we,
  output logic                  is_branch,
  output logic                  is_jal,
  output logic                  is_jalr,
  output logic                  halt_req
);
  import rv_isa_pkg::*;

  opcode_t    opcode;
  funct3_t    funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_b;
  word_t      imm_j;
  word_t      imm_u;
  logic       is_rr;
  logic       arith_ok; // funct7 legal for this alu encoding
  alu_op_t    arith_op;
  logic       writes;

  assign opcode = insn[6:0];
  assign rd     = insn[11:7];
  assign funct3 = insn[14:12];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];
  assign funct7 = insn[31:25];
  assign is_rr  = opcode == op_reg_reg;

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'h000};

  // alu op shared by reg-reg and reg-imm
  always_comb begin
    arith_op = alu_add;
    arith_ok = !is_rr || funct7 == funct7_base;
    case (funct3)
      3'b000: begin
        arith_op = (is_rr && funct7 == funct7_alt) ? alu_sub : alu_add;
        arith_ok = !is_rr || funct7 == funct7_base || funct7 == funct7_alt;
      end
      3'b001: begin
        arith_op = alu_sll;
        arith_ok = funct7 == funct7_base; // slli too
      end
      3'b010: arith_op = alu_slt;
      3'b011: arith_op = alu_sltu;
      3'b100: arith_op = alu_xor;
      3'b101: begin
        arith_op = (funct7 == funct7_alt) ? alu_sra : alu_srl;
        arith_ok = funct7 == funct7_base || funct7 == funct7_alt;
      end
      3'b110: arith_op = alu_or;
      default: arith_op = alu_and;
    endcase
  end

  always_comb begin
    imm       = imm_i;
    alu_op    = alu_add;
    a_sel_pc  = 1'b0;
    a_zero    = 1'b0;
    b_imm     = 1'b0;
    link      = 1'b0;
    writes    = 1'b0;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    is_jalr   = 1'b0;
    halt_req  = 1'b0;
    case (opcode)
      op_reg_reg: begin
        alu_op   = arith_op;
        writes   = 1'b1;
        halt_req = !arith_ok; // m extension lands here
      end
      op_reg_imm: begin
        alu_op   = arith_op;
        b_imm    = 1'b1;
        writes   = 1'b1;
        halt_req = !arith_ok;
      end
      op_lui: begin
        imm    = imm_u;
        a_zero = 1'b1; // 0 + imm
        b_imm  = 1'b1;
        writes = 1'b1;
      end
      op_auipc: begin
        imm      = imm_u;
        a_sel_pc = 1'b1;
        b_imm    = 1'b1;
        writes   = 1'b1;
      end
      op_jal: begin
        imm    = imm_j;
        link   = 1'b1;
        writes = 1'b1;
        is_jal = 1'b1;
      end
      op_jalr: begin
        link     = 1'b1;
        writes   = 1'b1;
        is_jalr  = 1'b1;
        halt_req = funct3 != 3'b000;
      end
      op_branch: begin
        imm       = imm_b;
        is_branch = 1'b1;
        halt_req  = funct3[2:1] == 2'b01; // no branch at 010, 011
      end
      op_misc_mem: halt_req = funct3 != 3'b000; // plain fence is a nop
      op_system:   halt_req = 1'b1;             // ecall, ebreak, csr
      default:     halt_req = 1'b1;
    endcase
  end

  assign rd_we = writes && !halt_req && rd != 5'd0;

endmodule

// File: hw/exec_unit.sv
module exec_unit (
  input  rv_isa_pkg::word_t   pc,
  input  rv_isa_pkg::word_t   rs1_data,
  input  rv_isa_pkg::word_t   rs2_data,
  input  rv_isa_pkg::word_t   imm,
  input  rv_isa_pkg::alu_op_t alu_op,
  input  logic                a_sel_pc,
  input  logic                a_zero,
  input  logic                b_imm,
  input  logic                link,
  input  rv_isa_pkg::funct3_t funct3,
  output rv_isa_pkg::word_t   wb_data,
  output logic                branch_taken
);
  import rv_isa_pkg::*;

  word_t      op_a;
  word_t      op_b;
  word_t      alu_res;
  logic [4:0] shamt;

  assign op_a  = a_zero ? '0 : (a_sel_pc ? pc : rs1_data);
  assign op_b  = b_imm ? imm : rs2_data;
  assign shamt = op_b[4:0]; // shifts use the low 5 bits only

  always_comb begin
    case (alu_op)
      alu_add:  alu_res = op_a + op_b;
      alu_sub:  alu_res = op_a - op_b;
      alu_sll:  alu_res = op_a << shamt;
      alu_slt:  alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
      alu_sltu: alu_res = {31'b0, op_a < op_b};
      alu_xor:  alu_res = op_a ^ op_b;
      alu_srl:  alu_res = op_a >> shamt;
      alu_sra:  alu_res = $signed(op_a) >>> shamt;
      alu_or:   alu_res = op_a | op_b;
      alu_and:  alu_res = op_a & op_b;
      default:  alu_res = '0;
    endcase
  end

  // branch condition always on rs1/rs2, next_pc gates it with is_branch
  always_comb begin
    case (funct3)
      3'b000:  branch_taken = rs1_data == rs2_data;
      3'b001:  branch_taken = rs1_data != rs2_data;
      3'b100:  branch_taken = $signed(rs1_data) < $signed(rs2_data);
      3'b101:  branch_taken = $signed(rs1_data) >= $signed(rs2_data);
      3'b110:  branch_taken = rs1_data < rs2_data;
      3'b111:  branch_taken = rs1_data >= rs2_data;
      default: branch_taken = 1'b0;
    endcase
  end

  assign wb_data = link ? pc + 32'd4 : alu_res; // jal/jalr return address

endmodule

// File: hw/next_pc.sv
module next_pc (
  input  logic              clk,
  input  logic              rst,
  input  logic              commit,
  input  logic              is_branch,
  input  logic              is_jal,
  input  logic              is_jalr,
  input  logic              branch_taken,
  input  rv_isa_pkg::word_t rs1_data,
  input  rv_isa_pkg::word_t imm,
  output rv_isa_pkg::word_t pc
);
  import rv_isa_pkg::*;
  import core_cfg_pkg::*;

  word_t pc_plus4;
  word_t pc_rel;   // jal and branch target
  word_t reg_rel;  // jalr target
  word_t pc_nxt;

  assign pc_plus4 = pc + 32'd4;
  assign pc_rel   = pc + imm;
  assign reg_rel  = (rs1_data + imm) & ~32'd1;

  always_comb begin
    if (is_jal || (is_branch && branch_taken)) begin
      pc_nxt = pc_rel;
    end else if (is_jalr) begin
      pc_nxt = reg_rel;
    end else begin
      pc_nxt = pc_plus4; // fall through, fence included
    end
  end

  // only moves at the end of a committed exec cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= reset_pc;
    end else if (commit) begin
      pc <= pc_nxt;
    end
  end

endmodule

// File: hw/core_ctrl.sv
module core_ctrl (
  input  logic clk,
  input  logic rst,
  input  logic start,
  input  logic halt_req,
  output logic fetch,
  output logic commit,
  output logic halt,
  output logic busy
);
  import core_cfg_pkg::*;

  core_state_t state;
  core_state_t state_nxt;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle:  if (start) state_nxt = st_fetch; // start ignored elsewhere
      st_fetch: state_nxt = st_exec;
      st_exec:  state_nxt = halt_req ? st_halt : st_fetch;
      default:  state_nxt = state; // halt sticks until reset
    endcase
  end

  assign fetch  = state == st_fetch;
  assign commit = state == st_exec && !halt_req; // no retire for the halting insn
  assign halt   = state == st_halt;
  assign busy   = fetch || state == st_exec;

endmodule

// File: hw/perf_counters.sv
module perf_counters (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 busy,
  input  logic                 commit,
  output core_cfg_pkg::count_t cycle_count,
  output core_cfg_pkg::count_t insn_count
);

  // both wrap at 2^32
  always_ff @(posedge clk) begin
    if (rst) begin
      cycle_count <= '0;
      insn_count  <= '0;
    end else begin
      if (busy) begin
        cycle_count <= cycle_count + 1'b1; // fetch and exec cycles only
      end
      if (commit) begin
        insn_count <= insn_count + 1'b1;
      end
    end
  end

endmodule

// File: hw/rv_core.sv
module rv_core #(
  parameter int imem_words = 256,
  localparam int load_addr_w = $clog2(imem_words)
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start,
  input  logic                   load_we,
  input  logic [load_addr_w-1:0] load_addr,
  input  rv_isa_pkg::word_t      load_data,
  output logic                   halt,
  output logic                   retire_valid,
  output rv_isa_pkg::word_t      retire_pc,
  output rv_isa_pkg::reg_addr_t  retire_rd,
  output logic                   retire_we,
  output rv_isa_pkg::word_t      retire_data,
  output core_cfg_pkg::count_t   cycle_count,
  output core_cfg_pkg::count_t   insn_count
);
  import rv_isa_pkg::*;

  logic      fetch;
  logic      commit;
  logic      busy;
  logic      halt_req;
  word_t     pc;
  word_t     insn;
  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;
  word_t     imm;
  alu_op_t   alu_op;
  logic      a_sel_pc;
  logic      a_zero;
  logic      b_imm;
  logic      link;
  logic      rd_we;
  logic      is_branch;
  logic      is_jal;
  logic      is_jalr;
  word_t     rs1_data;
  word_t     rs2_data;
  word_t     wb_data;
  logic      branch_taken;

  core_ctrl ctrl_i (
    .clk(clk), .rst(rst), .start(start), .halt_req(halt_req),
    .fetch(fetch), .commit(commit), .halt(halt), .busy(busy)
  );

  perf_counters perf_i (
    .clk(clk), .rst(rst), .busy(busy), .commit(commit),
    .cycle_count(cycle_count), .insn_count(insn_count)
  );

  insn_mem #(.imem_words(imem_words)) imem_i (
    .clk(clk), .load_we(load_we), .load_addr(load_addr), .load_data(load_data),
    .fetch(fetch), .pc(pc), .insn(insn)
  );

  insn_decode dec_i (
    .insn(insn), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .alu_op(alu_op),
    .a_sel_pc(a_sel_pc), .a_zero(a_zero), .b_imm(b_imm), .link(link), .rd_we(rd_we),
    .is_branch(is_branch), .is_jal(is_jal), .is_jalr(is_jalr), .halt_req(halt_req)
  );

  exec_unit exec_i (
    .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm), .alu_op(alu_op),
    .a_sel_pc(a_sel_pc), .a_zero(a_zero), .b_imm(b_imm), .link(link),
    .funct3(insn[14:12]), .wb_data(wb_data), .branch_taken(branch_taken)
  );

  next_pc pc_i (
    .clk(clk), .rst(rst), .commit(commit), .is_branch(is_branch), .is_jal(is_jal),
    .is_jalr(is_jalr), .branch_taken(branch_taken), .rs1_data(rs1_data), .imm(imm),
    .pc(pc)
  );

  reg_file rf_i (
    .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .rd(rd), .we(rd_we), .commit(commit),
    .wdata(wb_data), .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  // retire trace, valid for one cycle per instruction
  assign retire_valid = commit;
  assign retire_pc    = pc;
  assign retire_rd    = rd;
  assign retire_we    = rd_we;
  assign retire_data  = wb_data;

endmodule

// File: tests/rv_core_tests.svh
`ifndef RV_CORE_TESTS_SVH
`define RV_CORE_TESTS_SVH

function automatic word_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                 input reg_addr_t rs1, input funct3_t f3, input reg_addr_t rd);
  return {f7, rs2, rs1, f3, rd, op_reg_reg};
endfunction

function automatic word_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                 input funct3_t f3, input reg_addr_t rd, input opcode_t op);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic word_t b_type(input logic [12:0] imm, input reg_addr_t rs2,
                                 input reg_addr_t rs1, input funct3_t f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
endfunction

function automatic word_t j_type(input logic [20:0] imm, input reg_addr_t rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
endfunction

function automatic word_t u_type(input logic [19:0] imm, input reg_addr_t rd, input opcode_t op);
  return {imm, rd, op};
endfunction

// rv32i result rule per funct3 where alt selects sub and sra
function automatic word_t alu_result(input funct3_t f3, input logic alt, input word_t x,
                                     input word_t y);
  case (f3)
    3'd0:    return alt ? x - y : x + y;
    3'd1:    return x << y[4:0];
    3'd2:    return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
    3'd3:    return (x < y) ? 32'd1 : 32'd0;
    3'd4:    return x ^ y;
    3'd5:    return alt ? word_t'($signed(x) >>> y[4:0]) : x >> y[4:0];
    3'd6:    return x | y;
    default: return x & y;
  endcase
endfunction

task automatic alu_ops_test();
  funct3_t   rr_f3 [10]  = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
  logic      rr_alt [10] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
  funct3_t   ri_f3 [9]   = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5, 3'd5};
  logic      ri_alt [9]  = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
  word_t     r;
  word_t     a;
  word_t     b;
  logic [11:0] imm;
  reg_addr_t rd;
  r = $urandom;
  a = {{20{r[11]}}, r[11:0]};
  b = {{20{r[27]}}, r[27:16]};
  add_retiring(i_type(r[11:0], 5'd0, 3'd0, 5'd1, op_reg_imm), 5'd1, a);
  add_retiring(i_type(r[27:16], 5'd0, 3'd0, 5'd2, op_reg_imm), 5'd2, b);
  for (int k = 0; k < 10; k++) begin
    rd = reg_addr_t'(k + 3);
    add_retiring(r_type(rr_alt[k] ? funct7_alt : funct7_base, 5'd2, 5'd1, rr_f3[k], rd), rd,
                 alu_result(rr_f3[k], rr_alt[k], a, b));
  end
  for (int k = 0; k < 9; k++) begin
    r   = $urandom;
    rd  = reg_addr_t'(k + 13);
    imm = r[11:0];
    if (ri_f3[k] == 3'd1 || ri_f3[k] == 3'd5) begin
      imm = {ri_alt[k] ? funct7_alt : funct7_base, r[4:0]}; // shamt form
    end
    add_retiring(i_type(imm, 5'd1, ri_f3[k], rd, op_reg_imm), rd,
                 alu_result(ri_f3[k], ri_alt[k], a, {{20{imm[11]}}, imm}));
  end
  add_word(ecall_insn);
  run_program();
  report_test("alu ops");
endtask

task automatic upper_imm_test();
  word_t r;
  r = $urandom;
  add_retiring(u_type(r[19:0], 5'd5, op_lui), 5'd5, {r[19:0], 12'h000});
  add_retiring(u_type(r[31:12], 5'd6, op_auipc), 5'd6, 32'd4 + {r[31:12], 12'h000});
  add_retiring(i_type(12'h07b, 5'd0, 3'd0, 5'd0, op_reg_imm), 5'd0, 32'd0); // x0 takes no write
  add_retiring(r_type(funct7_base, 5'd0, 5'd5, 3'd0, 5'd7), 5'd7, {r[19:0], 12'h000});
  add_retiring(r_type(funct7_base, 5'd6, 5'd0, 3'd0, 5'd8), 5'd8, 32'd4 + {r[31:12], 12'h000});
  add_word(ecall_insn);
  run_program();
  report_test("lui, auipc and x0");
endtask

task automatic control_flow_test();
  funct3_t   br_f3 [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
  reg_addr_t src1 [3]  = '{5'd1, 5'd2, 5'd1};
  reg_addr_t src2 [3]  = '{5'd2, 5'd1, 5'd1};
  // x1 is -5 and x2 is 3, one row per branch in br_f3 order
  logic      taken [6][3] = '{'{1'b0, 1'b0, 1'b1},  // beq
                              '{1'b1, 1'b1, 1'b0},  // bne
                              '{1'b1, 1'b0, 1'b0},  // blt
                              '{1'b0, 1'b1, 1'b1},  // bge
                              '{1'b0, 1'b1, 1'b0},  // bltu
                              '{1'b1, 1'b0, 1'b1}}; // bgeu
  word_t     filler;
  word_t     p;
  filler = i_type(12'd1, 5'd0, 3'd0, 5'd9, op_reg_imm);
  add_retiring(i_type(12'hffb, 5'd0, 3'd0, 5'd1, op_reg_imm), 5'd1, 32'hffff_fffb);
  add_retiring(i_type(12'h003, 5'd0, 3'd0, 5'd2, op_reg_imm), 5'd2, 32'd3);
  for (int i = 0; i < 6; i++) begin
    for (int j = 0; j < 3; j++) begin
      p = word_t'(4 * prog.size());
      expect_retire(p, 5'd0, 1'b0, 32'd0);
      add_word(b_type(13'd8, src2[j], src1[j], br_f3[i])); // taken skips the filler
      if (taken[i][j]) begin
        add_word(filler);
      end else begin
        add_retiring(filler, 5'd9, 32'd1);
      end
    end
  end
  p = word_t'(4 * prog.size());
  add_retiring(j_type(21'd12, 5'd10), 5'd10, p + 32'd4);
  add_word(filler);
  add_word(filler);
  p = p + 32'd12;
  add_retiring(u_type(20'd0, 5'd11, op_auipc), 5'd11, p);
  // odd offset so bit 0 of the target gets cleared
  add_retiring(i_type(12'd13, 5'd11, 3'd0, 5'd12, op_jalr), 5'd12, p + 32'd8);
  add_word(filler);
  add_retiring(i_type(12'd7, 5'd0, 3'd0, 5'd13, op_reg_imm), 5'd13, 32'd7);
  add_word(ecall_insn);
  run_program();
  report_test("control flow");
endtask

task automatic ecall_halt_test();
  for (int i = 0; i < 5; i++) begin
    add_retiring(i_type(12'(i + 1), 5'd0, 3'd0, reg_addr_t'(i + 20), op_reg_imm),
                 reg_addr_t'(i + 20), word_t'(i + 1));
  end
  add_word(ecall_insn);
  run_program();
  for (int n = 0; n < 20; n++) begin
    @(negedge clk);
    check_bit("halt", halt, 1'b1);
    check_bit("retire_valid", retire_valid, 1'b0);
  end
  report_test("ecall halt");
endtask

task automatic illegal_encoding_test();
  word_t bad [3];
  string what [3] = '{"illegal load", "illegal mul", "illegal opcode"};
  bad[0] = i_type(12'd0, 5'd0, 3'b010, 5'd4, 7'b000_0011); // lw
  bad[1] = r_type(7'b000_0001, 5'd2, 5'd1, 3'd0, 5'd4);    // mul
  bad[2] = 32'h0000_002b;
  for (int i = 0; i < 3; i++) begin
    add_retiring(i_type(12'd77, 5'd0, 3'd0, 5'd3, op_reg_imm), 5'd3, 32'd77);
    add_word(bad[i]);
    run_program();
    report_test(what[i]);
  end
endtask

`endif

// File: tests/rv_core_tb.sv
module rv_core_tb;
  import rv_isa_pkg::*;
  import core_cfg_pkg::*;

  localparam int imem_words     = 256;
  localparam int addr_w         = $clog2(imem_words);
  localparam int retire_timeout = 50;  // cycles, one insn needs two
  localparam int halt_timeout   = 50;
  localparam word_t ecall_insn  = 32'h0000_0073;

  logic              clk = 1'b0;
  logic              rst;
  logic              start;
  logic              load_we;
  logic [addr_w-1:0] load_addr;
  word_t             load_data;
  logic              halt;
  logic              retire_valid;
  word_t             retire_pc;
  reg_addr_t         retire_rd;
  logic              retire_we;
  word_t             retire_data;
  count_t            cycle_count;
  count_t            insn_count;

  // program image and the retire sequence it should produce
  word_t     prog [$];
  word_t     exp_pc [$];
  logic      exp_we [$];
  reg_addr_t exp_rd [$];
  word_t     exp_data [$];

  int errors      = 0;
  int errs_before = 0;
  int runs        = 0;
  int failed_runs = 0;

  always #50 clk = ~clk;

  rv_core #(.imem_words(imem_words)) rv_core_i (
    .clk(clk), .rst(rst), .start(start), .load_we(load_we), .load_addr(load_addr),
    .load_data(load_data), .halt(halt), .retire_valid(retire_valid),
    .retire_pc(retire_pc), .retire_rd(retire_rd), .retire_we(retire_we),
    .retire_data(retire_data), .cycle_count(cycle_count), .insn_count(insn_count)
  );

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input count_t got, input count_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  function automatic void add_word(input word_t w);
    prog.push_back(w);
  endfunction

  function automatic void expect_retire(input word_t pc, input reg_addr_t rd, input logic we,
                                        input word_t data);
    exp_pc.push_back(pc);
    exp_rd.push_back(rd);
    exp_we.push_back(we);
    exp_data.push_back(data);
  endfunction

  // word at the next linear address, expected to retire in order
  function automatic void add_retiring(input word_t w, input reg_addr_t rd, input word_t data);
    expect_retire(word_t'(4 * prog.size()), rd, rd != 5'd0, data);
    add_word(w);
  endfunction

  task automatic apply_reset();
    @(posedge clk);
    rst <= 1'b1;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic load_program();
    for (int i = 0; i < prog.size(); i++) begin
      @(posedge clk);
      load_we   <= 1'b1;
      load_addr <= addr_w'(i);
      load_data <= prog[i];
    end
    @(posedge clk);
    load_we <= 1'b0;
    start   <= 1'b1; // one-cycle pulse
    @(posedge clk);
    start <= 1'b0;
  endtask

  // outputs sampled on the falling edge, mid-cycle
  task automatic next_retire(output logic seen);
    seen = 1'b0;
    for (int n = 0; n < retire_timeout && !seen; n++) begin
      @(negedge clk);
      seen = retire_valid;
    end
    if (!seen) begin
      $display("timeout: no instruction retired within %0d cycles", retire_timeout);
      errors++;
    end
  endtask

  task automatic wait_halt();
    logic seen;
    seen = 1'b0;
    for (int n = 0; n < halt_timeout && !seen; n++) begin
      @(negedge clk);
      if (retire_valid) begin
        $display("unexpected retire at pc %h while waiting for halt", retire_pc);
        errors++;
      end
      seen = halt;
    end
    if (!seen) begin
      $display("timeout: core did not halt within %0d cycles", halt_timeout);
      errors++;
    end
  endtask

  task automatic run_program();
    logic seen;
    errs_before = errors;
    apply_reset();
    load_program();
    for (int i = 0; i < exp_pc.size(); i++) begin
      next_retire(seen);
      if (!seen) begin
        break;
      end
      check_word("retire_pc", retire_pc, exp_pc[i]);
      check_bit("retire_we", retire_we, exp_we[i]);
      if (exp_we[i]) begin
        check_reg("retire_rd", retire_rd, exp_rd[i]);
        check_word("retire_data", retire_data, exp_data[i]);
      end
    end
    wait_halt();
    // n retired plus the halting insn, two cycles each
    check_count("insn_count", insn_count, count_t'(exp_pc.size()));
    check_count("cycle_count", cycle_count, count_t'(2 * (exp_pc.size() + 1)));
    prog.delete();
    exp_pc.delete();
    exp_rd.delete();
    exp_we.delete();
    exp_data.delete();
  endtask

  task automatic report_test(input string name);
    int errs;
    errs = errors - errs_before;
    runs++;
    if (errs == 0) begin
      $display("test %s: ok", name);
    end else begin
      failed_runs++;
      $display("test %s: %0d errors", name, errs);
    end
  endtask

  `include "rv_core_tests.svh"

  initial begin
    rst       = 1'b1;
    start     = 1'b0;
    load_we   = 1'b0;
    load_addr = '0;
    load_data = '0;
    void'($urandom(32'hece57e42));
    alu_ops_test();
    upper_imm_test();
    control_flow_test();
    ecall_halt_test();
    illegal_encoding_test();
    $display("runs %0d, failed runs %0d, failed checks %0d", runs, failed_runs, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: list.f
+incdir+tests
hw/rv_isa_pkg.sv
hw/core_cfg_pkg.sv
hw/insn_mem.sv
hw/reg_file.sv
hw/insn_decode.sv
hw/exec_unit.sv
hw/next_pc.sv
hw/core_ctrl.sv
hw/perf_counters.sv
hw/rv_core.sv
tests/rv_core_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f list.f --top-module rv_core_tb
out=$(./obj_dir/Vrv_core_tb)
echo "$out"
echo "$out" | grep -q "Simulation finished: PASS"
